// ==== src/mipsPkg.sv ====
`default_nettype none

package mipsPkg;

    // Data and address word
    typedef logic [31:0] wordT;

    // Instruction fields
    typedef logic [4:0]  regIdxT;
    typedef logic [5:0]  opcodeT;
    typedef logic [5:0]  functT;
    typedef logic [4:0]  shamtT;
    typedef logic [15:0] imm16T;
    typedef logic [25:0] jumpTargetT;

    // Data memory word address from byte address bits 8 to 2
    typedef logic [6:0]  memAddrT;

    // Operation class from the main decoder
    typedef logic [1:0]  aluClassT;

    // ALU operation code
    typedef logic [3:0]  aluOpT;

    // Primary opcodes
    localparam opcodeT OP_RTYPE = 6'h00;
    localparam opcodeT OP_J     = 6'h02;
    localparam opcodeT OP_JAL   = 6'h03;
    localparam opcodeT OP_BEQ   = 6'h04;
    localparam opcodeT OP_BNE   = 6'h05;
    localparam opcodeT OP_ADDI  = 6'h08;
    localparam opcodeT OP_LW    = 6'h23;
    localparam opcodeT OP_SW    = 6'h2B;

    // R-type function codes
    localparam functT FN_SLL = 6'h00;
    localparam functT FN_SRL = 6'h02;
    localparam functT FN_JR  = 6'h08;
    localparam functT FN_ADD = 6'h20;
    localparam functT FN_SUB = 6'h22;
    localparam functT FN_AND = 6'h24;
    localparam functT FN_OR  = 6'h25;
    localparam functT FN_NOR = 6'h27;
    localparam functT FN_SLT = 6'h2A;

    // ALU operation codes
    localparam aluOpT ALU_AND   = 4'b0000;
    localparam aluOpT ALU_OR    = 4'b0001;
    localparam aluOpT ALU_ADD   = 4'b0010;
    localparam aluOpT ALU_SUB   = 4'b0110;
    localparam aluOpT ALU_SLT   = 4'b0111;
    localparam aluOpT ALU_NOR   = 4'b1100;
    localparam aluOpT ALU_SRL   = 4'b1101;
    localparam aluOpT ALU_SUBNE = 4'b1110;
    localparam aluOpT ALU_SLL   = 4'b1111;

    // Operation classes
    localparam aluClassT CLASS_ADD   = 2'b00;
    localparam aluClassT CLASS_BEQ   = 2'b01;
    localparam aluClassT CLASS_RTYPE = 2'b10;
    localparam aluClassT CLASS_BNE   = 2'b11;

    // Link register for jal
    localparam regIdxT RA_REG = 5'd31;

    // Second operand select
    localparam logic [1:0] SRC_REG   = 2'b00;
    localparam logic [1:0] SRC_IMM   = 2'b01;
    localparam logic [1:0] SRC_SHAMT = 2'b11;

endpackage

`default_nettype wire

// ==== src/mainDecoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module mainDecoder (
    input  wire mipsPkg::opcodeT   opcode,
    input  wire mipsPkg::functT    funct,
    output logic                   regDst,
    output logic                   regWrite,
    output logic                   memToReg,
    output logic                   linkReturn,
    output logic                   branch,
    output logic                   jump,
    output logic                   jumpReg,
    output logic                   memCen,
    output logic                   memWen,
    output logic                   memOen,
    output logic [1:0]             aluSrc,
    output mipsPkg::aluClassT      aluClass
);
    import mipsPkg::*;

    always_comb begin
        // No-operation defaults
        // Memory disabled with output enable parked low
        regDst     = 1'b0;
        regWrite   = 1'b0;
        memToReg   = 1'b0;
        linkReturn = 1'b0;
        branch     = 1'b0;
        jump       = 1'b0;
        jumpReg    = 1'b0;
        memCen     = 1'b1;
        memWen     = 1'b1;
        memOen     = 1'b0;
        aluSrc     = SRC_REG;
        aluClass   = CLASS_ADD;

        case (opcode)
            OP_RTYPE: begin
                aluClass = CLASS_RTYPE;
                case (funct)
                    FN_ADD, FN_SUB, FN_AND, FN_OR, FN_NOR, FN_SLT: begin
                        regDst   = 1'b1;
                        regWrite = 1'b1;
                    end
                    FN_SLL, FN_SRL: begin
                        // Shift amount comes from the instruction
                        regDst   = 1'b1;
                        regWrite = 1'b1;
                        aluSrc   = SRC_SHAMT;
                    end
                    FN_JR: begin
                        // Jump through rs with nothing written back
                        jumpReg = 1'b1;
                    end
                    default: begin
                        // Unknown function stays a no-operation
                        regWrite = 1'b0;
                    end
                endcase
            end
            OP_ADDI: begin
                regWrite = 1'b1;
                aluSrc   = SRC_IMM;
            end
            OP_BEQ: begin
                branch   = 1'b1;
                aluClass = CLASS_BEQ;
            end
            OP_BNE: begin
                branch   = 1'b1;
                aluClass = CLASS_BNE;
            end
            OP_J: begin
                jump = 1'b1;
            end
            OP_JAL: begin
                // Return address into register 31
                jump       = 1'b1;
                regWrite   = 1'b1;
                linkReturn = 1'b1;
            end
            OP_LW: begin
                regWrite = 1'b1;
                memToReg = 1'b1;
                aluSrc   = SRC_IMM;
                memCen   = 1'b0;
                memOen   = 1'b0;
                memWen   = 1'b1;
            end
            OP_SW: begin
                aluSrc = SRC_IMM;
                memCen = 1'b0;
                memOen = 1'b1;
                memWen = 1'b0;
            end
            default: begin
                // Undefined opcode keeps the no-operation defaults
                regWrite = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/aluDecoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module aluDecoder (
    input  wire mipsPkg::aluClassT aluClass,
    input  wire mipsPkg::functT    funct,
    output mipsPkg::aluOpT         aluOp
);
    import mipsPkg::*;

    always_comb begin
        case (aluClass)
            // Loads, stores and addi form an address or a sum
            CLASS_ADD: begin
                aluOp = ALU_ADD;
            end
            // beq compares by subtraction
            CLASS_BEQ: begin
                aluOp = ALU_SUB;
            end
            // bne uses the inverted compare
            CLASS_BNE: begin
                aluOp = ALU_SUBNE;
            end
            // R-type picks by function code
            default: begin
                case (funct)
                    FN_ADD:  aluOp = ALU_ADD;
                    FN_SUB:  aluOp = ALU_SUB;
                    FN_AND:  aluOp = ALU_AND;
                    FN_OR:   aluOp = ALU_OR;
                    FN_NOR:  aluOp = ALU_NOR;
                    FN_SLT:  aluOp = ALU_SLT;
                    FN_SLL:  aluOp = ALU_SLL;
                    FN_SRL:  aluOp = ALU_SRL;
                    // jr and unknown codes fall back to add
                    default: aluOp = ALU_ADD;
                endcase
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  wire mipsPkg::wordT  readData1,
    input  wire mipsPkg::wordT  readData2,
    input  wire mipsPkg::imm16T imm,
    input  wire mipsPkg::shamtT shamt,
    input  wire [1:0]           aluSrc,
    input  wire mipsPkg::aluOpT aluOp,
    output mipsPkg::wordT       aluResult,
    output logic                takeBranch
);
    import mipsPkg::*;

    wordT immExt;
    wordT shamtExt;
    wordT operandB;
    logic operandsEqual;

    // Sign-extended immediate
    assign immExt   = {{16{imm[15]}}, imm};
    // Zero-extended shift amount
    assign shamtExt = {27'd0, shamt};

    // Second operand select
    always_comb begin
        case (aluSrc)
            SRC_IMM:   operandB = immExt;
            SRC_SHAMT: operandB = shamtExt;
            default:   operandB = readData2;
        endcase
    end

    assign operandsEqual = (readData1 == operandB);

    always_comb begin
        case (aluOp)
            ALU_AND:   aluResult = readData1 & operandB;
            ALU_OR:    aluResult = readData1 | operandB;
            ALU_NOR:   aluResult = ~(readData1 | operandB);
            ALU_ADD:   aluResult = readData1 + operandB;
            ALU_SUB:   aluResult = readData1 - operandB;
            ALU_SUBNE: aluResult = readData1 - operandB;
            // Signed compare, result is 0 or 1
            ALU_SLT:   aluResult = {31'd0, $signed(readData1) < $signed(operandB)};
            // Logical shifts use the low five bits only
            ALU_SLL:   aluResult = readData1 << operandB[4:0];
            ALU_SRL:   aluResult = readData1 >> operandB[4:0];
            default:   aluResult = '0;
        endcase
    end

    // Branch condition
    // beq on equal operands, bne on differing ones
    always_comb begin
        case (aluOp)
            ALU_SUB:   takeBranch = operandsEqual;
            ALU_SUBNE: takeBranch = ~operandsEqual;
            default:   takeBranch = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/registerBank.sv ====
`timescale 1ns/100ps
`default_nettype none

module registerBank (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire mipsPkg::regIdxT rs,
    input  wire mipsPkg::regIdxT rt,
    input  wire mipsPkg::regIdxT rd,
    input  wire                  regDst,
    input  wire                  regWrite,
    input  wire                  memToReg,
    input  wire                  linkReturn,
    input  wire mipsPkg::wordT   aluResult,
    input  wire mipsPkg::wordT   memReadData,
    input  wire mipsPkg::wordT   pcPlus4,
    output mipsPkg::wordT        readData1,
    output mipsPkg::wordT        readData2
);
    import mipsPkg::*;

    wordT   regs [32];
    regIdxT writeReg;
    wordT   writeData;

    // Combinational reads, register 0 is hard zero
    assign readData1 = (rs == 5'd0) ? '0 : regs[rs];
    assign readData2 = (rt == 5'd0) ? '0 : regs[rt];

    // Destination is rd for R-type, 31 for jal, else rt
    assign writeReg = regDst ? rd : (linkReturn ? RA_REG : rt);

    // Write-back source
    assign writeData = memToReg ? memReadData : (linkReturn ? pcPlus4 : aluResult);

    // Reset is active while rst_n is high
    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && (writeReg != 5'd0)) begin
            // Writes to register 0 are dropped
            regs[writeReg] <= writeData;
        end
    end

endmodule

`default_nettype wire

// ==== src/pcUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

module pcUnit (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire mipsPkg::imm16T      imm,
    input  wire mipsPkg::jumpTargetT target,
    input  wire                      jump,
    input  wire                      jumpReg,
    input  wire                      branch,
    input  wire                      takeBranch,
    input  wire mipsPkg::wordT       regTarget,
    output mipsPkg::wordT            instrAddr,
    output mipsPkg::wordT            pcPlus4
);
    import mipsPkg::*;

    wordT branchOffset;
    wordT jumpAddr;
    wordT nextPc;

    assign pcPlus4 = instrAddr + 32'd4;

    // Word offset to byte offset
    assign branchOffset = {{14{imm[15]}}, imm, 2'b00};

    // Jump stays inside the current 256 MB region
    assign jumpAddr = {instrAddr[31:28], target, 2'b00};

    // Jump first, then jr, then a taken branch
    always_comb begin
        if (jump) begin
            nextPc = jumpAddr;
        end else if (jumpReg) begin
            nextPc = regTarget;
        end else if (branch && takeBranch) begin
            nextPc = pcPlus4 + branchOffset;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            instrAddr <= '0;
        end else begin
            instrAddr <= nextPc;
        end
    end

endmodule

`default_nettype wire

// ==== src/singleCycleMips.sv ====
`timescale 1ns/100ps
`default_nettype none

module singleCycleMips (
    input  wire                clk,
    input  wire                rst_n,
    output mipsPkg::wordT      instrAddr,
    input  wire mipsPkg::wordT instr,
    input  wire mipsPkg::wordT memReadData,
    output logic               memCen,
    output logic               memWen,
    output logic               memOen,
    output mipsPkg::memAddrT   memAddr,
    output mipsPkg::wordT      memWriteData
);
    import mipsPkg::*;

    // Instruction fields
    opcodeT     opcode;
    regIdxT     rs;
    regIdxT     rt;
    regIdxT     rd;
    shamtT      shamt;
    functT      funct;
    imm16T      imm;
    jumpTargetT target;

    // Controls
    logic       regDst;
    logic       regWrite;
    logic       memToReg;
    logic       linkReturn;
    logic       branch;
    logic       jump;
    logic       jumpReg;
    logic [1:0] aluSrc;
    aluClassT   aluClass;
    aluOpT      aluOp;

    // Datapath
    logic       shiftOp;
    regIdxT     readReg1;
    wordT       readData1;
    wordT       readData2;
    wordT       aluResult;
    logic       takeBranch;
    wordT       pcPlus4;

    assign opcode = instr[31:26];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign shamt  = instr[10:6];
    assign funct  = instr[5:0];
    assign imm    = instr[15:0];
    assign target = instr[25:0];

    // sll and srl shift rt, so rt goes on the first read port
    assign shiftOp  = (opcode == OP_RTYPE) && ((funct == FN_SLL) || (funct == FN_SRL));
    assign readReg1 = shiftOp ? rt : rs;

    // Word address and store data
    assign memAddr      = aluResult[8:2];
    assign memWriteData = readData2;

    mainDecoder mainDecoder_inst (
        .opcode(opcode), .funct(funct),
        .regDst(regDst), .regWrite(regWrite), .memToReg(memToReg),
        .linkReturn(linkReturn), .branch(branch), .jump(jump), .jumpReg(jumpReg),
        .memCen(memCen), .memWen(memWen), .memOen(memOen),
        .aluSrc(aluSrc), .aluClass(aluClass)
    );

    aluDecoder aluDecoder_inst (.aluClass(aluClass), .funct(funct), .aluOp(aluOp));

    alu alu_inst (
        .readData1(readData1), .readData2(readData2), .imm(imm), .shamt(shamt),
        .aluSrc(aluSrc), .aluOp(aluOp), .aluResult(aluResult), .takeBranch(takeBranch)
    );

    registerBank registerBank_inst (
        .clk(clk), .rst_n(rst_n), .rs(readReg1), .rt(rt), .rd(rd),
        .regDst(regDst), .regWrite(regWrite), .memToReg(memToReg),
        .linkReturn(linkReturn), .aluResult(aluResult), .memReadData(memReadData),
        .pcPlus4(pcPlus4), .readData1(readData1), .readData2(readData2)
    );

    // jr target is the rs register word
    pcUnit pcUnit_inst (
        .clk(clk), .rst_n(rst_n), .imm(imm), .target(target),
        .jump(jump), .jumpReg(jumpReg), .branch(branch), .takeBranch(takeBranch),
        .regTarget(readData1), .instrAddr(instrAddr), .pcPlus4(pcPlus4)
    );

endmodule

`default_nettype wire

// ==== sim/mipsChecker.sv ====
`timescale 1ns/100ps
`default_nettype none

module mipsChecker (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire mipsPkg::wordT   instrAddr,
    input  wire                  memCen,
    input  wire                  memWen,
    input  wire                  memOen,
    input  wire mipsPkg::memAddrT memAddr,
    input  wire mipsPkg::wordT   memWriteData,
    output logic                 done,
    output int                   errorCount,
    output int                   totalCycles
);
    import mipsPkg::*;

    // Raw stimulus words as the testbench top loads them
    logic [31:0] stim [256];
    int          testErrors;

    task automatic flagMismatch(input string sigName, input wordT expected, input wordT actual);
        $display("mismatch %s: expected %08h, got %08h", sigName, expected, actual);
        testErrors++;
        errorCount++;
    endtask

    task automatic flagFailure(input string what);
        $display("%s", what);
        testErrors++;
        errorCount++;
    endtask

    // One cycle of one test
    // pcIdx points at the expected address
    task automatic checkCycle(input int pcIdx, input int nStores, input int storeBase,
                              input int cycle);
        logic expectStore;
        wordT expAddr;
        wordT expData;
        expectStore = 1'b0;
        expAddr     = '0;
        expData     = '0;
        if (instrAddr !== stim[pcIdx]) begin
            flagMismatch("instrAddr", stim[pcIdx], instrAddr);
        end
        // Store records hold address, data and cycle
        for (int s = 0; s < nStores; s++) begin
            if (stim[storeBase + 3 * s + 2] == cycle) begin
                expectStore = 1'b1;
                expAddr     = stim[storeBase + 3 * s];
                expData     = stim[storeBase + 3 * s + 1];
            end
        end
        if (expectStore) begin
            if (memCen !== 1'b0 || memWen !== 1'b0) begin
                flagFailure($sformatf("expected store to word %0h in cycle %0d never appeared",
                                      expAddr, cycle));
            end else begin
                if (memOen !== 1'b1) begin
                    flagMismatch("memOen", 32'd1, {31'd0, memOen});
                end
                if ({25'd0, memAddr} !== expAddr) begin
                    flagMismatch("memAddr", expAddr, {25'd0, memAddr});
                end
                if (memWriteData !== expData) begin
                    flagMismatch("memWriteData", expData, memWriteData);
                end
            end
        end else begin
            if (memWen !== 1'b1) begin
                flagFailure($sformatf("store to word %0h in cycle %0d was not expected",
                                      memAddr, cycle));
            end
            // Output enable low outside stores
            if (memOen !== 1'b0) begin
                flagMismatch("memOen", 32'd0, {31'd0, memOen});
            end
        end
    endtask

    initial begin
        int          idx;
        int          testBase;
        int          nTests;
        int          nCycles;
        int          nStores;
        int          pcBase;
        int          storeBase;
        int          passed;
        int          failed;
        logic [31:0] testName;
        done        = 1'b0;
        errorCount  = 0;
        passed      = 0;
        failed      = 0;
        totalCycles = 0;
        $readmemh("sim/programStim.txt", stim);

        // Skip program words and preload pairs
        idx      = stim[0] + 1;
        idx      = idx + 2 * stim[idx] + 1;
        testBase = idx;
        nTests   = stim[idx];

        // Sum of cycles over all tests for the timeout in the top
        idx = testBase + 1;
        for (int t = 0; t < nTests; t++) begin
            nCycles     = stim[idx + 1];
            nStores     = stim[idx + 2 + nCycles];
            totalCycles = totalCycles + nCycles;
            idx         = idx + 3 + nCycles + 3 * nStores;
        end

        // Reset phase with PC parked at 0 and memory idle
        testErrors = 0;
        @(posedge clk);
        @(negedge clk);
        while (rst_n) begin
            if (instrAddr !== 32'd0) begin
                flagMismatch("instrAddr", 32'd0, instrAddr);
            end
            if (memCen !== 1'b1 || memWen !== 1'b1) begin
                flagFailure("memory strobes active during reset");
            end
            @(negedge clk);
        end
        $display("test reset: %s", (testErrors == 0) ? "passed" : "failed");
        if (testErrors == 0) begin
            passed++;
        end else begin
            failed++;
        end

        // Tests run back to back
        // First cycle is the current negedge
        idx = testBase + 1;
        for (int t = 0; t < nTests; t++) begin
            testErrors = 0;
            testName   = stim[idx];
            nCycles    = stim[idx + 1];
            pcBase     = idx + 2;
            nStores    = stim[pcBase + nCycles];
            storeBase  = pcBase + nCycles + 1;
            for (int c = 0; c < nCycles; c++) begin
                if (t != 0 || c != 0) begin
                    @(negedge clk);
                end
                checkCycle(pcBase + c, nStores, storeBase, c);
            end
            $display("test %s: %s, %0d errors", testName,
                     (testErrors == 0) ? "passed" : "failed", testErrors);
            if (testErrors == 0) begin
                passed++;
            end else begin
                failed++;
            end
            idx = storeBase + 3 * nStores;
        end

        $display("tests passed %0d, failed %0d, errors %0d", passed, failed, errorCount);
        done = 1'b1;
    end

endmodule

`default_nettype wire

// ==== sim/tbSingleCycleMips.sv ====
`timescale 1ns/100ps
`default_nettype none

module tbSingleCycleMips;
    import mipsPkg::*;

    logic        clk;
    logic        rst_n;
    wordT        instr;
    wordT        instrAddr;
    wordT        memReadData;
    wordT        memWriteData;
    logic        memCen;
    logic        memWen;
    logic        memOen;
    memAddrT     memAddr;
    logic        done;
    int          errorCount;
    int          totalCycles;

    // Program ROM and data memory of 128 words each
    wordT        rom [128];
    wordT        dmem [128];
    logic [31:0] stim [256];

    // 20 ns period
    initial begin
        clk = 1'b0;
    end
    always #10 clk = ~clk;

    // Load program and preloads from the stimulus image
    initial begin
        int idx;
        int nPre;
        $readmemh("sim/programStim.txt", stim);
        for (int i = 0; i < 128; i++) begin
            // Unused ROM words are sll $0 no-operations
            rom[i]  = '0;
            // Fill tagged with the word address
            dmem[i] = {16'hD0D0, 9'd0, 7'(i)};
        end
        for (int i = 0; i < int'(stim[0]); i++) begin
            rom[i] = stim[i + 1];
        end
        idx  = stim[0] + 1;
        nPre = stim[idx];
        for (int p = 0; p < nPre; p++) begin
            dmem[stim[idx + 1 + 2 * p][6:0]] = stim[idx + 2 + 2 * p];
        end
    end

    // Combinational read port
    // Drives data only with chip and output enable low
    assign memReadData = (!memCen && !memOen) ? dmem[memAddr] : '0;

    // Write on the edge with chip and write enable low
    always @(posedge clk) begin
        if (!memCen && !memWen) begin
            dmem[memAddr] <= memWriteData;
        end
    end

    // Reset held for 3 cycles
    // Inputs move 2 ns after the edge
    initial begin
        rst_n = 1'b1;
        instr = '0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b0;
        instr = rom[instrAddr[8:2]];
        forever begin
            @(posedge clk);
            #2;
            instr = rom[instrAddr[8:2]];
        end
    end

    singleCycleMips singleCycleMips_inst (
        .clk(clk), .rst_n(rst_n), .instrAddr(instrAddr), .instr(instr),
        .memReadData(memReadData), .memCen(memCen), .memWen(memWen), .memOen(memOen),
        .memAddr(memAddr), .memWriteData(memWriteData)
    );

    mipsChecker mipsChecker_inst (
        .clk(clk), .rst_n(rst_n), .instrAddr(instrAddr), .memCen(memCen),
        .memWen(memWen), .memOen(memOen), .memAddr(memAddr),
        .memWriteData(memWriteData), .done(done), .errorCount(errorCount),
        .totalCycles(totalCycles)
    );

    // Cycle limit from the test lengths
    initial begin
        int cycleCount;
        int limit;
        cycleCount = 0;
        @(negedge rst_n);
        limit = 2 * totalCycles + 20;
        while (!done && cycleCount < limit) begin
            @(posedge clk);
            cycleCount++;
        end
        if (done && errorCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            if (!done) begin
                $display("timeout after %0d cycles, checker did not finish", limit);
            end
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/programStim.txt ====
// Program count and words, preload count and (word address, data) pairs,
// test count, then per test: name, cycles, PCs, store count, (address, data, cycle)
27
20010005 2002FFFD 00221820 00412022 0041282A 00223024 00223825 00204027
20000007 AC030000 AC040004 AC050008 AC06000C AC070010 AC080014 AC000018
00014900 00075202 8C0B0100 200C0020 AD890008 AD8A000C AD8BFFFC
200D0002 21ADFFFF 15A0FFFE 11A00001 200E0077 10200001 AC0D0030 AC0E0034
08000022 200F0001 200F0002 0C000026 AC1F0038 08000024 200F0003 03E00008
1
40 CAFEF00D
4
// ALU and register 0
414C5520 10
0 4 8 C 10 14 18 1C 20 24 28 2C 30 34 38 3C
7
0 2 9
1 FFFFFFF8 A
2 1 B
3 5 C
4 FFFFFFFD D
5 FFFFFFFA E
6 0 F
// Shifts, load and store copy
53484654 7
40 44 48 4C 50 54 58
3
A 50 4
B 00FFFFFF 5
7 CAFEF00D 6
// Branches with a backward loop
42524348 9
5C 60 64 60 64 68 70 74 78
2
C 0 7
D 0 8
// j, jal and jr
4A554D50 6
7C 88 98 8C 90 90
1
E 8C 3

// ==== sources.f ====
src/mipsPkg.sv
src/mainDecoder.sv
src/aluDecoder.sv
src/alu.sv
src/registerBank.sv
src/pcUnit.sv
src/singleCycleMips.sv
sim/mipsChecker.sv
sim/tbSingleCycleMips.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tbSingleCycleMips -f sources.f -o simv \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/simv > sim.log 2>&1
cat sim.log

grep -qx "Simulation completed successfully" sim.log && exit 0 || exit 1
